/* rv_pkg.sv */
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;

  localparam word_t RESET_PC  = 32'h0000_0000;
  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // Encoded as the branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_type_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;
  typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
  typedef enum logic       {OP2_RS2, OP2_IMM} op2_sel_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wb_sel_e;

  typedef struct packed {
    alu_op_e      alu_op;
    op1_sel_e     op1_sel;
    op2_sel_e     op2_sel;
    wb_sel_e      wb_sel;
    logic         reg_write;
    logic         mem_read;
    logic         mem_write;
    logic         branch;
    logic         jump;
    logic         is_jalr;
    branch_type_e branch_type;
    logic [2:0]   mem_funct3;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    ctrl_t    ctrl;
    reg_idx_t rd;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
  } de_stage_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

/* rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  output word_t    rdata1,
  output word_t    rdata2,
  input  wb_t      wb
);

  // Entry 0 is cleared on reset and never written
  word_t regs [0:31];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // Holds even after an instruction has targeted x0
  assert property (@(posedge clk) disable iff (rst)
    (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0))
    else $error("x0 read returned a nonzero value");

endmodule

/* rv_fetch.sv */
`timescale 1ns/1ns

module rv_fetch import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  stall,
  input  logic  branch_taken,
  input  word_t branch_target,
  output word_t instr_addr,
  input  word_t instr_rdata,
  output word_t fd_instr,
  output word_t fd_pc
);

  word_t pc;

  assign instr_addr = pc;

  // Redirect wins over a load-use hold
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // Fetch/decode register, a flushed slot decodes as a NOP
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fd_instr <= NOP_INSTR;
      fd_pc    <= RESET_PC;
    end else if (branch_taken) begin
      fd_instr <= NOP_INSTR;
      fd_pc    <= pc;
    end else if (!stall) begin
      fd_instr <= instr_rdata;
      fd_pc    <= pc;
    end
  end

  // Branch and JALR targets from execute must keep the PC aligned
  assert property (@(posedge clk) disable iff (rst) instr_addr[1:0] == 2'b00)
    else $error("misaligned fetch address %h", instr_addr);

endmodule

/* rv_decode.sv */
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  word_t     fd_instr,
  input  word_t     fd_pc,
  input  word_t     rdata1,
  input  word_t     rdata2,
  output reg_idx_t  raddr1,
  output reg_idx_t  raddr2,
  input  wb_t       wb,
  input  reg_idx_t  ex_load_rd,
  input  logic      ex_load,
  input  logic      branch_taken,
  output logic      stall,
  output de_stage_t de
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_alt;
  ctrl_t      ctrl;
  imm_type_e  imm_type;
  logic       use_rs1;
  logic       use_rs2;
  word_t      imm;
  word_t      rs1_val;
  word_t      rs2_val;

  assign opcode     = fd_instr[6:0];
  assign funct3     = fd_instr[14:12];
  assign funct7_alt = fd_instr[30];
  assign raddr1     = fd_instr[19:15];
  assign raddr2     = fd_instr[24:20];

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    // Zero means add of rs1 and rs2 with no side effects
    ctrl             = '0;
    ctrl.branch_type = branch_type_e'(funct3);
    ctrl.mem_funct3  = funct3;
    imm_type         = IMM_I;
    use_rs1          = 1'b0;
    use_rs2          = 1'b0;
    case (opcode)
      OPC_LUI: begin
        imm_type = IMM_U;
        {ctrl.op1_sel, ctrl.op2_sel, ctrl.wb_sel} = {OP1_ZERO, OP2_IMM, WB_IMM};
        ctrl.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        imm_type = IMM_U;
        {ctrl.op1_sel, ctrl.op2_sel} = {OP1_PC, OP2_IMM};
        ctrl.reg_write = 1'b1;
      end
      OPC_JAL: begin
        imm_type = IMM_J;
        {ctrl.jump, ctrl.reg_write, ctrl.wb_sel} = {2'b11, WB_PC4};
      end
      OPC_JALR: begin
        use_rs1 = 1'b1;
        {ctrl.jump, ctrl.is_jalr, ctrl.reg_write, ctrl.wb_sel} = {3'b111, WB_PC4};
      end
      OPC_BRANCH: begin
        imm_type = IMM_B;
        {use_rs1, use_rs2, ctrl.branch} = 3'b111;
      end
      OPC_LOAD: begin
        use_rs1 = 1'b1;
        {ctrl.op2_sel, ctrl.wb_sel} = {OP2_IMM, WB_MEM};
        {ctrl.mem_read, ctrl.reg_write} = 2'b11;
      end
      OPC_STORE: begin
        imm_type = IMM_S;
        {use_rs1, use_rs2, ctrl.mem_write} = 3'b111;
        ctrl.op2_sel = OP2_IMM;
      end
      OPC_OPIMM: begin
        use_rs1 = 1'b1;
        // Bit 30 selects SRAI only, it is part of the immediate elsewhere
        ctrl.alu_op    = alu_decode(funct3, funct7_alt && funct3 == 3'b101);
        ctrl.op2_sel   = OP2_IMM;
        ctrl.reg_write = 1'b1;
      end
      OPC_OP: begin
        {use_rs1, use_rs2, ctrl.reg_write} = 3'b111;
        ctrl.alu_op = alu_decode(funct3, funct7_alt);
      end
      default: ;
    endcase
  end

  always_comb begin
    case (imm_type)
      IMM_S:   imm = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
      IMM_B:   imm = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7],
                      fd_instr[30:25], fd_instr[11:8], 1'b0};
      IMM_U:   imm = {fd_instr[31:12], 12'b0};
      IMM_J:   imm = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12],
                      fd_instr[20], fd_instr[30:21], 1'b0};
      default: imm = {{20{fd_instr[31]}}, fd_instr[31:20]};
    endcase
  end

  // Execute result bypasses the register file
  assign rs1_val = (wb.we && wb.rd == raddr1 && raddr1 != '0) ? wb.data : rdata1;
  assign rs2_val = (wb.we && wb.rd == raddr2 && raddr2 != '0) ? wb.data : rdata2;

  // Load data arrives too late to forward, hold one cycle
  assign stall = ex_load && ex_load_rd != '0 &&
                 ((use_rs1 && raddr1 == ex_load_rd) || (use_rs2 && raddr2 == ex_load_rd));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      de <= '0;
    end else if (stall || branch_taken) begin
      de <= '0;
    end else begin
      de <= '{valid: 1'b1, pc: fd_pc, ctrl: ctrl, rd: fd_instr[11:7],
              rs1_val: rs1_val, rs2_val: rs2_val, imm: imm};
    end
  end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
  input  de_stage_t de,
  output word_t     alu_result,
  output logic      branch_taken,
  output word_t     branch_target,
  output word_t     data_addr,
  output word_t     data_wdata,
  output byte_en_t  data_we,
  output logic      data_re
);

  word_t    op1;
  word_t    op2;
  logic     cond;
  byte_en_t store_be;
  word_t    store_data;
  word_t    jalr_sum;

  always_comb begin
    case (de.ctrl.op1_sel)
      OP1_PC:   op1 = de.pc;
      OP1_ZERO: op1 = '0;
      default:  op1 = de.rs1_val;
    endcase
    op2 = (de.ctrl.op2_sel == OP2_IMM) ? de.imm : de.rs2_val;
  end

  always_comb begin
    case (de.ctrl.alu_op)
      ALU_SUB:  alu_result = op1 - op2;
      ALU_SLL:  alu_result = op1 << op2[4:0];
      ALU_SLT:  alu_result = {31'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_result = {31'b0, op1 < op2};
      ALU_XOR:  alu_result = op1 ^ op2;
      ALU_SRL:  alu_result = op1 >> op2[4:0];
      ALU_SRA:  alu_result = $signed(op1) >>> op2[4:0];
      ALU_OR:   alu_result = op1 | op2;
      ALU_AND:  alu_result = op1 & op2;
      default:  alu_result = op1 + op2;
    endcase
  end

  // Branches compare the raw register operands
  always_comb begin
    case (de.ctrl.branch_type)
      BR_NE:   cond = de.rs1_val != de.rs2_val;
      BR_LT:   cond = $signed(de.rs1_val) < $signed(de.rs2_val);
      BR_GE:   cond = $signed(de.rs1_val) >= $signed(de.rs2_val);
      BR_LTU:  cond = de.rs1_val < de.rs2_val;
      BR_GEU:  cond = de.rs1_val >= de.rs2_val;
      default: cond = de.rs1_val == de.rs2_val;
    endcase
  end

  assign jalr_sum      = de.rs1_val + de.imm;
  assign branch_target = de.ctrl.is_jalr ? {jalr_sum[31:1], 1'b0} : de.pc + de.imm;
  assign branch_taken  = de.valid && (de.ctrl.jump || (de.ctrl.branch && cond));

  // Replicate store data across lanes, enables pick the lane
  always_comb begin
    case (de.ctrl.mem_funct3[1:0])
      2'b00: begin
        store_be   = 4'b0001 << alu_result[1:0];
        store_data = {4{de.rs2_val[7:0]}};
      end
      2'b01: begin
        store_be   = alu_result[1] ? 4'b1100 : 4'b0011;
        store_data = {2{de.rs2_val[15:0]}};
      end
      default: begin
        store_be   = 4'b1111;
        store_data = de.rs2_val;
      end
    endcase
  end

  // Address is rs1 plus imm for both loads and stores
  assign data_addr  = alu_result;
  assign data_wdata = store_data;
  assign data_we    = (de.valid && de.ctrl.mem_write) ? store_be : 4'b0000;
  assign data_re    = de.valid && de.ctrl.mem_read;

  always_comb begin
    assert final (!(data_re && data_we != '0))
      else $error("data port read and write in the same cycle");
  end

endmodule

/* rv_result.sv */
`timescale 1ns/1ns

module rv_result import rv_pkg::*; (
  input  de_stage_t de,
  input  word_t     alu_result,
  input  word_t     data_rdata,
  output wb_t       wb
);

  logic [1:0]  addr_low;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  word_t       load_data;

  // Only the low address bits matter for lane selection
  assign addr_low = de.rs1_val[1:0] + de.imm[1:0];
  assign ld_byte  = data_rdata[8*addr_low +: 8];
  assign ld_half  = addr_low[1] ? data_rdata[31:16] : data_rdata[15:0];

  always_comb begin
    case (de.ctrl.mem_funct3)
      3'b000:  load_data = {{24{ld_byte[7]}}, ld_byte};
      3'b001:  load_data = {{16{ld_half[15]}}, ld_half};
      3'b100:  load_data = {24'b0, ld_byte};
      3'b101:  load_data = {16'b0, ld_half};
      default: load_data = data_rdata;
    endcase
  end

  always_comb begin
    wb.we = de.valid && de.ctrl.reg_write;
    wb.rd = de.rd;
    case (de.ctrl.wb_sel)
      WB_MEM:  wb.data = load_data;
      // Link value for JAL and JALR
      WB_PC4:  wb.data = de.pc + 32'd4;
      WB_IMM:  wb.data = de.imm;
      default: wb.data = alu_result;
    endcase
  end

endmodule

/* rv_core.sv */
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  output word_t    instr_addr,
  input  word_t    instr_rdata,
  output word_t    data_addr,
  output word_t    data_wdata,
  output byte_en_t data_we,
  output logic     data_re,
  input  word_t    data_rdata
);

  word_t     fd_instr;
  word_t     fd_pc;
  logic      stall;
  logic      branch_taken;
  word_t     branch_target;
  reg_idx_t  raddr1;
  reg_idx_t  raddr2;
  word_t     rdata1;
  word_t     rdata2;
  wb_t       wb;
  de_stage_t de;
  word_t     alu_result;
  logic      ex_load;
  reg_idx_t  ex_load_rd;

  // Load in execute, seen by the hazard check in decode
  assign ex_load    = de.valid && de.ctrl.mem_read;
  assign ex_load_rd = de.rd;

  rv_fetch u_fetch (.clk, .rst, .stall, .branch_taken, .branch_target,
                    .instr_addr, .instr_rdata, .fd_instr, .fd_pc);

  rv_decode u_decode (.clk, .rst, .fd_instr, .fd_pc, .rdata1, .rdata2,
                      .raddr1, .raddr2, .wb, .ex_load_rd, .ex_load,
                      .branch_taken, .stall, .de);

  rv_regfile u_regfile (.clk, .rst, .raddr1, .raddr2, .rdata1, .rdata2, .wb);

  rv_execute u_execute (.de, .alu_result, .branch_taken, .branch_target,
                        .data_addr, .data_wdata, .data_we, .data_re);

  rv_result u_result (.de, .alu_result, .data_rdata, .wb);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for 16 cycles, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb import rv_pkg::*; ();

  localparam word_t MARK_ADDR  = 32'h0000_00f0;
  localparam word_t DONE_ADDR  = 32'h0000_00fc;
  localparam int    MAX_CYCLES = 2000;

  logic     clk;
  logic     rst;
  word_t    instr_addr;
  word_t    instr_rdata;
  word_t    data_addr;
  word_t    data_wdata;
  byte_en_t data_we;
  logic     data_re;
  word_t    data_rdata;

  word_t    prog [0:127];
  word_t    dmem [0:63];
  word_t    exp_addr [0:63];
  byte_en_t exp_be [0:63];
  word_t    exp_data [0:63];
  int       prog_len;
  int       n_exp;
  int       store_count;

  tb_clock_gen clock_gen (.clk, .rst);

  rv_core uut (.clk, .rst, .instr_addr, .instr_rdata, .data_addr, .data_wdata,
               .data_we, .data_re, .data_rdata);

  // Combinational instruction and data reads
  assign instr_rdata = (instr_addr < 32'h200) ? prog[instr_addr[8:2]] : NOP_INSTR;
  // Read data is only valid while data_re is high
  assign data_rdata  = data_re ? dmem[data_addr[7:2]] : 'x;

  // Byte-enabled write at the end of the store cycle
  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (data_we[i]) begin
        dmem[data_addr[7:2]][8*i +: 8] <= data_wdata[8*i +: 8];
      end
    end
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      store_count <= 0;
    end else if (data_we != '0) begin
      store_count <= store_count + 1;
    end
  end

  task automatic report_error(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  function automatic word_t enabled_bytes(word_t w, byte_en_t be);
    return w & {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  assert property (@(posedge clk) rst |-> data_we == '0 && !data_re)
    else report_error("data port active during reset");

  assert property (@(posedge clk) $fell(rst) |-> instr_addr == RESET_PC)
    else report_error($sformatf("first fetch at %h", $sampled(instr_addr)));

  // Each store must be the next entry of the expected table
  assert property (@(posedge clk) disable iff (rst)
    data_we != '0 |-> store_count < n_exp && data_addr == exp_addr[store_count] &&
      data_we == exp_be[store_count] &&
      enabled_bytes(data_wdata, data_we) == enabled_bytes(exp_data[store_count], data_we))
    else report_error($sformatf("store %0d to %h be %b data %h is not the expected one",
      $sampled(store_count), $sampled(data_addr), $sampled(data_we), $sampled(data_wdata)));

  assert property (@(posedge clk) disable iff (rst) data_we != '0 |-> data_addr != MARK_ADDR)
    else report_error("store from a flushed slot reached memory");

  // Also catches a JALR target whose bit 0 was not cleared
  assert property (@(posedge clk) disable iff (rst) instr_addr[1:0] == 2'b00)
    else report_error($sformatf("fetch from unaligned address %h", $sampled(instr_addr)));

  // Instruction encoders
  function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic word_t enc_i(logic [6:0] opc, int rd, int f3, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic word_t enc_s(int f3, int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(int f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_u(logic [6:0] opc, int rd, int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic word_t enc_j(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  task automatic emit(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // Store from rs2 to offset(x0) and its expected table entry
  task automatic emit_store(input int f3, input int rs2, input int offset, input word_t value);
    logic [1:0] lane;
    byte_en_t   size_mask;
    lane      = offset[1:0];
    size_mask = (f3 == 0) ? 4'b0001 : (f3 == 1) ? 4'b0011 : 4'b1111;
    emit(enc_s(f3, rs2, 0, offset));
    exp_addr[n_exp] = word_t'(offset);
    exp_be[n_exp]   = size_mask << lane;
    exp_data[n_exp] = value << (8 * lane);
    n_exp++;
  endtask

  // Sits in a slot that a taken branch must squash
  task automatic emit_flushed_store();
    emit(enc_s(2, 0, 0, MARK_ADDR));
    emit(enc_s(2, 0, 0, MARK_ADDR));
  endtask

  // Load into x13, then store x13 right away
  task automatic load_then_store(input int f3, input int src, input int dst, input word_t v);
    emit(enc_i(OPC_LOAD, 13, f3, 0, src));
    emit_store(2, 13, dst, v);
  endtask

  task automatic build_program();
    word_t a, b, c, d, e, f, w10, w12;
    int    pc_jal;
    int    pc_jalr;
    for (int i = 0; i < 128; i++) begin
      prog[i] = NOP_INSTR;
    end
    prog_len = 0;
    n_exp    = 0;
    // Dependent ALU chain
    a = 32'h1234_5678;
    b = a - 32'd3;
    c = (b ^ a) << 4;
    d = c - b;
    e = {{3{d[31]}}, d[31:3]};
    f = ((e < d) ? 32'd1 : 32'd0) | e;
    emit(enc_u(OPC_LUI, 1, 'h12345));
    emit(enc_i(OPC_OPIMM, 1, 0, 1, 'h678));
    emit(enc_i(OPC_OPIMM, 2, 0, 1, -3));
    emit(enc_r(0, 1, 2, 4, 3));
    emit(enc_i(OPC_OPIMM, 3, 1, 3, 4));
    emit(enc_r('h20, 2, 3, 0, 4));
    emit(enc_i(OPC_OPIMM, 5, 5, 4, 'h403));
    emit(enc_r(0, 4, 5, 3, 6));
    emit(enc_r(0, 5, 6, 6, 6));
    emit_store(2, 6, 'h00, f);
    emit_store(2, 4, 'h04, d);
    emit_store(2, 4, 'h04, d);
    emit(enc_u(OPC_AUIPC, 7, 1));
    emit_store(2, 7, 'h08, word_t'(4 * (prog_len - 1)) + 32'h1000);
    // Load-use
    emit(enc_i(OPC_LOAD, 8, 2, 0, 0));
    emit(enc_r(0, 1, 8, 0, 9));
    emit_store(2, 9, 'h0c, f + a);
    // Sub-word stores over a known word
    w10 = 32'h8899_b000 - 32'd1349;
    w12 = 32'hffff_8081;
    emit(enc_u(OPC_LUI, 10, 'h8899b));
    emit(enc_i(OPC_OPIMM, 10, 0, 10, -1349));
    emit(enc_i(OPC_OPIMM, 11, 0, 0, 'h7e));
    emit(enc_u(OPC_LUI, 12, 'hffff8));
    emit(enc_i(OPC_OPIMM, 12, 0, 12, 'h081));
    emit_store(2, 10, 'h10, w10);
    emit_store(0, 11, 'h10, 32'h7e);
    emit_store(0, 12, 'h13, w12);
    emit_store(2, 10, 'h18, w10);
    emit_store(0, 11, 'h19, 32'h7e);
    emit_store(0, 12, 'h1a, w12);
    emit_store(2, 10, 'h20, w10);
    emit_store(1, 12, 'h22, w12);
    emit_store(2, 10, 'h24, w10);
    emit_store(1, 11, 'h24, 32'h7e);
    load_then_store(2, 'h10, 'h40, {w12[7:0], w10[23:8], 8'h7e});
    load_then_store(2, 'h18, 'h44, {w10[31:24], w12[7:0], 8'h7e, w10[7:0]});
    load_then_store(2, 'h20, 'h48, {w12[15:0], w10[15:0]});
    load_then_store(2, 'h24, 'h4c, {w10[31:16], 16'h007e});
    // LB, LBU, LH, LHU
    load_then_store(0, 'h13, 'h70, {{24{w12[7]}}, w12[7:0]});
    load_then_store(4, 'h13, 'h74, {24'b0, w12[7:0]});
    load_then_store(1, 'h22, 'h78, {{16{w12[15]}}, w12[15:0]});
    load_then_store(5, 'h22, 'h7c, {16'b0, w12[15:0]});
    load_then_store(0, 'h19, 'h80, 32'h0000_007e);
    load_then_store(1, 'h24, 'h84, 32'h0000_007e);
    // Branches on 5 and -3
    emit(enc_i(OPC_OPIMM, 20, 0, 0, 5));
    emit(enc_i(OPC_OPIMM, 21, 0, 0, -3));
    emit(enc_b(0, 20, 21, 12));
    emit_store(2, 20, 'h50, 32'd5);
    emit(enc_b(1, 20, 21, 12));
    emit_flushed_store();
    emit(enc_b(4, 21, 20, 12));
    emit_flushed_store();
    emit(enc_b(5, 21, 20, 12));
    emit_store(2, 21, 'h54, -32'sd3);
    emit(enc_b(6, 21, 20, 12));
    emit_store(2, 20, 'h58, 32'd5);
    emit(enc_b(7, 21, 20, 12));
    emit_flushed_store();
    emit_store(2, 21, 'h5c, -32'sd3);
    // JAL, then JALR to an odd address
    pc_jal = 4 * prog_len;
    emit(enc_j(23, 12));
    emit_flushed_store();
    emit_store(2, 23, 'h60, word_t'(pc_jal + 4));
    pc_jalr = 4 * (prog_len + 1);
    emit(enc_i(OPC_OPIMM, 24, 0, 0, pc_jalr + 13));
    emit(enc_i(OPC_JALR, 25, 0, 24, 0));
    emit_flushed_store();
    emit_store(2, 25, 'h64, word_t'(pc_jalr + 4));
    // Done store, then spin in place
    emit(enc_i(OPC_OPIMM, 26, 0, 0, 1));
    emit_store(2, 26, DONE_ADDR, 32'd1);
    emit(enc_j(0, 0));
  endtask

  initial begin
    int cycles;
    for (int i = 0; i < 64; i++) begin
      dmem[i] = 32'hc0de_0000 | (i << 2);
    end
    build_program();
    cycles = 0;
    while (rst !== 1'b0) begin
      @(negedge clk);
      cycles++;
      if (cycles > 100) begin
        stop_on_timeout("reset release");
      end
    end
    cycles = 0;
    while (!(data_we == 4'b1111 && data_addr == DONE_ADDR)) begin
      @(negedge clk);
      cycles++;
      if (cycles > MAX_CYCLES) begin
        stop_on_timeout("the store to the done address");
      end
    end
    // One more edge so the done store is checked and counted
    @(negedge clk);
    if (store_count == n_exp) begin
      $display("** PASS **");
      $finish;
    end else begin
      report_error($sformatf("%0d stores seen, %0d expected", store_count, n_exp));
    end
  end

endmodule

/* sim.f */
rv_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_clock_gen.sv
rv_core_tb.sv
